// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_clock_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= test passed
FAIL_MSG  ?= test failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi
	@echo "simulation ok"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/alarm_unit.sv
`timescale 1ns/1ns
`default_nettype none

module alarm_unit import clock_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  hms_t i_time,
	input  inc_t i_inc,
	input  logic i_alarm_en,
	output hms_t o_alarm_time,
	output logic o_alarm
);

	logic match;

	// alarm time, set one field at a time
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm_time <= '0;
		else if (|i_inc)
			o_alarm_time <= hms_apply_inc(o_alarm_time, i_inc);
	end

	assign match = (i_time == o_alarm_time);	// hr, min and sec all equal

	// ------------------------------------------------------------------------
	// alarm latch
	// ------------------------------------------------------------------------
	// held until the enable is switched off, even after the time moves on
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm <= 1'b0;
		else if (!i_alarm_en)
			o_alarm <= 1'b0;
		else if (match)
			o_alarm <= 1'b1;
	end

endmodule

`default_nettype wire

// File: hdl/clock_pkg.sv
`default_nettype none

package clock_pkg;

	// ------------------------------------------------------------------------
	// sizes and limits
	// ------------------------------------------------------------------------
	localparam int NUM_DIGITS   = 6;
	localparam int DEF_SEC_DIV  = 50_000_000;	// 50 MHz board clock
	localparam int DEF_SCAN_DIV = 5_000;	// clk cycles per digit
	localparam int BLINK_SCANS  = 2_500;	// scan strobes per half blink period

	typedef logic [5:0]            unit_t;	// one time field, binary
	typedef logic [3:0]            bcd_t;
	typedef logic [6:0]            seg_t;	// {a, b, c, d, e, f, g}, active high
	typedef logic [NUM_DIGITS-1:0] digit_enb_t;	// active low, bit 0 rightmost

	localparam unit_t SEC_MAX = 6'd59;
	localparam unit_t MIN_MAX = 6'd59;
	localparam unit_t HR_MAX  = 6'd23;
	localparam seg_t SEG_BLANK = 7'b000_0000;

	typedef enum logic [1:0] {
		MODE_CLOCK     = 2'd0,
		MODE_SET_TIME  = 2'd1,
		MODE_SET_ALARM = 2'd2
	} mode_t;

	typedef enum logic [1:0] {
		POS_SEC = 2'd0,
		POS_MIN = 2'd1,
		POS_HR  = 2'd2
	} pos_t;

	typedef struct packed {
		unit_t hr;
		unit_t min;
		unit_t sec;
	} hms_t;

	typedef struct packed {
		logic mode;
		logic pos;
		logic inc;
		logic alarm_en;
	} keys_t;

	typedef struct packed {
		logic sec;
		logic min;
		logic hr;
	} inc_t;

	// ------------------------------------------------------------------------
	// helpers shared by the time and alarm registers
	// ------------------------------------------------------------------------
	function automatic unit_t unit_wrap_inc(unit_t v, unit_t max);
		return (v >= max) ? '0 : unit_t'(v + 1'b1);
	endfunction

	// manual set, each field wraps on its own, no carry
	function automatic hms_t hms_apply_inc(hms_t t, inc_t inc);
		hms_t r;
		r = t;
		if (inc.sec)
			r.sec = unit_wrap_inc(t.sec, SEC_MAX);
		if (inc.min)
			r.min = unit_wrap_inc(t.min, MIN_MAX);
		if (inc.hr)
			r.hr = unit_wrap_inc(t.hr, HR_MAX);
		return r;
	endfunction

	function automatic seg_t seg_decode(bcd_t d);
		case (d)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_1011;
			default: return SEG_BLANK;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: hdl/clock_top.sv
`timescale 1ns/1ns
`default_nettype none

module clock_top import clock_pkg::*; #(
	parameter int SEC_DIV  = DEF_SEC_DIV,
	parameter int SCAN_DIV = DEF_SCAN_DIV
) (
	input  logic       clk,
	input  logic       rst_n,
	input  keys_t      i_keys,
	output seg_t       o_seg,
	output digit_enb_t o_seg_enb,
	output logic       o_alarm
);

	logic  sec_tick;
	logic  scan_tick;
	logic  blink_on;
	keys_t press;
	mode_t mode;
	pos_t  pos;
	inc_t  time_inc;
	inc_t  alarm_inc;
	logic  run;
	logic  alarm_en;
	hms_t  time_now;
	hms_t  alarm_time;

	tick_gen #(
		.SEC_DIV  (SEC_DIV),
		.SCAN_DIV (SCAN_DIV)
	) tick_gen_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.o_sec_tick  (sec_tick),
		.o_scan_tick (scan_tick),
		.o_blink_on  (blink_on)
	);

	key_cond key_cond_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_keys  (i_keys),
		.o_press (press)
	);

	mode_ctrl mode_ctrl_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_press     (press),
		.o_mode      (mode),
		.o_pos       (pos),
		.o_time_inc  (time_inc),
		.o_alarm_inc (alarm_inc),
		.o_run       (run),
		.o_alarm_en  (alarm_en)
	);

	timekeeper timekeeper_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_sec_tick (sec_tick),
		.i_run      (run),
		.i_inc      (time_inc),
		.o_time     (time_now)
	);

	alarm_unit alarm_unit_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_time       (time_now),
		.i_inc        (alarm_inc),
		.i_alarm_en   (alarm_en),
		.o_alarm_time (alarm_time),
		.o_alarm      (o_alarm)
	);

	display_mux display_mux_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_time       (time_now),
		.i_alarm_time (alarm_time),
		.i_mode       (mode),
		.i_pos        (pos),
		.i_scan_tick  (scan_tick),
		.i_blink_on   (blink_on),
		.o_seg        (o_seg),
		.o_seg_enb    (o_seg_enb)
	);

endmodule

`default_nettype wire

// File: hdl/display_mux.sv
`timescale 1ns/1ns
`default_nettype none

module display_mux import clock_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  hms_t       i_time,
	input  hms_t       i_alarm_time,
	input  mode_t      i_mode,
	input  pos_t       i_pos,
	input  logic       i_scan_tick,
	input  logic       i_blink_on,
	output seg_t       o_seg,
	output digit_enb_t o_seg_enb
);

	typedef logic [$clog2(NUM_DIGITS)-1:0] digit_idx_t;

	digit_idx_t idx_q;	// digit being driven
	hms_t       shown;
	bcd_t       digit;
	logic       in_field;	// digit belongs to the field being set
	logic       blank;

	assign shown = (i_mode == MODE_SET_ALARM) ? i_alarm_time : i_time;

	// ------------------------------------------------------------------------
	// digit value, 0 is the rightmost
	// ------------------------------------------------------------------------
	always_comb begin
		case (idx_q)
			3'd0:    digit = bcd_t'(shown.sec % 10);
			3'd1:    digit = bcd_t'(shown.sec / 10);
			3'd2:    digit = bcd_t'(shown.min % 10);
			3'd3:    digit = bcd_t'(shown.min / 10);
			3'd4:    digit = bcd_t'(shown.hr % 10);
			3'd5:    digit = bcd_t'(shown.hr / 10);
			default: digit = '0;
		endcase
	end

	always_comb begin
		case (i_pos)
			POS_SEC: in_field = (idx_q == 3'd0) || (idx_q == 3'd1);
			POS_MIN: in_field = (idx_q == 3'd2) || (idx_q == 3'd3);
			POS_HR:  in_field = (idx_q == 3'd4) || (idx_q == 3'd5);
			default: in_field = 1'b0;
		endcase
	end

	// selected field goes dark in the off half of the blink
	assign blank = (i_mode != MODE_CLOCK) && in_field && !i_blink_on;

	// ------------------------------------------------------------------------
	// scanning
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			idx_q <= '0;
		else if (i_scan_tick)
			idx_q <= (idx_q == digit_idx_t'(NUM_DIGITS - 1)) ? '0 : idx_q + 1'b1;
	end

	// segments and enable come from the same index in the same edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_seg     <= SEG_BLANK;
			o_seg_enb <= ~digit_enb_t'(1);	// digit 0
		end else begin
			o_seg     <= blank ? SEG_BLANK : seg_decode(digit);
			o_seg_enb <= ~(digit_enb_t'(1) << idx_q);
		end
	end

endmodule

`default_nettype wire

// File: hdl/key_cond.sv
`timescale 1ns/1ns
`default_nettype none

module key_cond import clock_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  keys_t i_keys,	// raw button levels
	output keys_t o_press
);

	keys_t sync1;
	keys_t sync2;
	keys_t prev;	// sync2 one cycle late

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync1 <= '0;
			sync2 <= '0;
			prev  <= '0;
		end else begin
			sync1 <= i_keys;
			sync2 <= sync1;
			prev  <= sync2;
		end
	end

	// rising edge of the synchronized level, one pulse per press
	assign o_press = sync2 & ~prev;

endmodule

`default_nettype wire

// File: hdl/mode_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module mode_ctrl import clock_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  keys_t i_press,
	output mode_t o_mode,
	output pos_t  o_pos,
	output inc_t  o_time_inc,
	output inc_t  o_alarm_inc,
	output logic  o_run,
	output logic  o_alarm_en
);

	inc_t field_inc;

	// ------------------------------------------------------------------------
	// mode FSM, field position and alarm enable
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode <= MODE_CLOCK;
		end else if (i_press.mode) begin
			case (o_mode)
				MODE_CLOCK:    o_mode <= MODE_SET_TIME;
				MODE_SET_TIME: o_mode <= MODE_SET_ALARM;
				default:       o_mode <= MODE_CLOCK;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_pos <= POS_SEC;
		end else if (i_press.pos) begin
			case (o_pos)
				POS_SEC: o_pos <= POS_MIN;
				POS_MIN: o_pos <= POS_HR;
				default: o_pos <= POS_SEC;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm_en <= 1'b0;
		else if (i_press.alarm_en)
			o_alarm_en <= ~o_alarm_en;	// toggle
	end

	// ------------------------------------------------------------------------
	// increment strobes, same cycle as the press
	// ------------------------------------------------------------------------
	always_comb begin
		field_inc = '0;
		if (i_press.inc) begin
			case (o_pos)
				POS_SEC: field_inc.sec = 1'b1;
				POS_MIN: field_inc.min = 1'b1;
				POS_HR:  field_inc.hr  = 1'b1;
				default: field_inc     = '0;
			endcase
		end
	end

	assign o_time_inc  = (o_mode == MODE_SET_TIME)  ? field_inc : '0;
	assign o_alarm_inc = (o_mode == MODE_SET_ALARM) ? field_inc : '0;
	assign o_run       = (o_mode != MODE_SET_TIME);	// time frozen while being set

endmodule

`default_nettype wire

// File: hdl/tick_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tick_gen import clock_pkg::*; #(
	parameter int SEC_DIV  = DEF_SEC_DIV,
	parameter int SCAN_DIV = DEF_SCAN_DIV
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_sec_tick,
	output logic o_scan_tick,
	output logic o_blink_on
);

	typedef logic [$clog2(SEC_DIV)-1:0]     sec_cnt_t;
	typedef logic [$clog2(SCAN_DIV)-1:0]    scan_cnt_t;
	typedef logic [$clog2(BLINK_SCANS)-1:0] blink_cnt_t;

	sec_cnt_t   sec_cnt;
	scan_cnt_t  scan_cnt;
	blink_cnt_t blink_cnt;

	// one strobe per second
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sec_cnt    <= sec_cnt_t'(SEC_DIV - 1);
			o_sec_tick <= 1'b0;
		end else begin
			o_sec_tick <= (sec_cnt == '0);
			sec_cnt    <= (sec_cnt == '0) ? sec_cnt_t'(SEC_DIV - 1) : sec_cnt - 1'b1;
		end
	end

	// one strobe per displayed digit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_cnt    <= scan_cnt_t'(SCAN_DIV - 1);
			o_scan_tick <= 1'b0;
		end else begin
			o_scan_tick <= (scan_cnt == '0);
			scan_cnt    <= (scan_cnt == '0) ? scan_cnt_t'(SCAN_DIV - 1) : scan_cnt - 1'b1;
		end
	end

	// blink phase counts scan strobes, starts visible
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			blink_cnt  <= blink_cnt_t'(BLINK_SCANS - 1);
			o_blink_on <= 1'b1;
		end else if (o_scan_tick) begin
			if (blink_cnt == '0) begin
				blink_cnt  <= blink_cnt_t'(BLINK_SCANS - 1);
				o_blink_on <= ~o_blink_on;
			end else begin
				blink_cnt <= blink_cnt - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/timekeeper.sv
`timescale 1ns/1ns
`default_nettype none

module timekeeper import clock_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic i_sec_tick,
	input  logic i_run,
	input  inc_t i_inc,
	output hms_t o_time
);

	hms_t time_next;	// time one second later

	// seconds into minutes into hours
	always_comb begin
		time_next     = o_time;
		time_next.sec = unit_wrap_inc(o_time.sec, SEC_MAX);
		if (o_time.sec == SEC_MAX) begin
			time_next.min = unit_wrap_inc(o_time.min, MIN_MAX);
			if (o_time.min == MIN_MAX)
				time_next.hr = unit_wrap_inc(o_time.hr, HR_MAX);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_time <= '0;
		else if (|i_inc)
			o_time <= hms_apply_inc(o_time, i_inc);	// manual set wins
		else if (i_sec_tick && i_run)
			o_time <= time_next;
	end

endmodule

`default_nettype wire

// File: sim/clock_assert.sv
`timescale 1ns/1ns
`default_nettype none

module clock_assert import clock_pkg::*; (
	input logic       clk,
	input logic       rst_n,
	input seg_t       i_seg,
	input digit_enb_t i_seg_enb,
	input logic       i_alarm
);

	int         fail_count = 0;	// failed assertions so far
	digit_enb_t enb_prev;
	logic       enb_moved;	// scanning has started
	logic       seg_ok;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enb_prev  <= i_seg_enb;
			enb_moved <= 1'b0;
		end else begin
			enb_prev <= i_seg_enb;
			if (i_seg_enb != enb_prev)
				enb_moved <= 1'b1;
		end
	end

	// blank or one of the ten digit shapes, a is the msb
	always_comb begin
		case (i_seg)
			SEG_BLANK,
			7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
			7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_1011:
				seg_ok = 1'b1;
			default:
				seg_ok = 1'b0;
		endcase
	end

	// --------------------------------------------------------------------------
	// port checks
	// --------------------------------------------------------------------------
	a_one_digit: assert property (@(posedge clk) disable iff (!rst_n) $onehot(~i_seg_enb))
		else begin
			fail_count++;
			$error("digit enables are not one-hot low");
		end

	a_seg_valid: assert property (@(posedge clk) disable iff (!rst_n) seg_ok)
		else begin
			fail_count++;
			$error("segment pattern is neither blank nor a digit");
		end

	a_alarm_in_reset: assert property (@(posedge clk) !rst_n |-> !i_alarm)
		else begin
			fail_count++;
			$error("alarm output high during reset");
		end

	a_alarm_after_scan: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(i_alarm) |-> enb_moved)
		else begin
			fail_count++;
			$error("alarm rose before the display started scanning");
		end

endmodule

bind clock_top clock_assert clock_assert_inst (
	.clk       (clk),
	.rst_n     (rst_n),
	.i_seg     (o_seg),
	.i_seg_enb (o_seg_enb),
	.i_alarm   (o_alarm)
);

`default_nettype wire

// File: sim/tb_clock_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_top import clock_pkg::*; ();

	localparam int TB_SEC_DIV  = 40;
	localparam int TB_SCAN_DIV = 2;
	localparam int READ_LIMIT  = 12_000;	// covers a full blink off phase
	localparam int READ_TRIES  = 40;
	localparam int ALARM_LIMIT = 400;
	localparam int DAY_SECS    = 86_400;

	logic       clk = 1'b0;
	logic       rst_n;
	keys_t      i_keys;
	seg_t       o_seg;
	digit_enb_t o_seg_enb;
	logic       o_alarm;

	keys_t k_mode;
	keys_t k_pos;
	keys_t k_inc;
	keys_t k_alarm;
	int    errors = 0;
	int    checks = 0;

	always #50 clk = ~clk;

	clock_top #(
		.SEC_DIV  (TB_SEC_DIV),
		.SCAN_DIV (TB_SCAN_DIV)
	) clock_top_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_keys    (i_keys),
		.o_seg     (o_seg),
		.o_seg_enb (o_seg_enb),
		.o_alarm   (o_alarm)
	);

	// --------------------------------------------------------------------------
	// helpers
	// --------------------------------------------------------------------------
	function automatic int seg_to_digit(seg_t s);
		case (s)
			7'b111_1110: return 0;
			7'b011_0000: return 1;
			7'b110_1101: return 2;
			7'b111_1001: return 3;
			7'b011_0011: return 4;
			7'b101_1011: return 5;
			7'b101_1111: return 6;
			7'b111_0000: return 7;
			7'b111_1111: return 8;
			7'b111_1011: return 9;
			default:     return -1;
		endcase
	endfunction

	function automatic int enb_to_index(digit_enb_t e);
		int idx;
		int lows;
		idx  = -1;
		lows = 0;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			if (!e[i]) begin
				idx = i;
				lows++;
			end
		end
		return (lows == 1) ? idx : -1;
	endfunction

	function automatic int to_secs(hms_t t);
		return int'(t.hr) * 3600 + int'(t.min) * 60 + int'(t.sec);
	endfunction

	function automatic hms_t from_secs(int s);
		hms_t r;
		r.hr  = unit_t'(s / 3600);
		r.min = unit_t'((s / 60) % 60);
		r.sec = unit_t'(s % 60);
		return r;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#5;
	endtask

	// held 4 cycles, then low for 4
	task automatic press_keys(input keys_t k, input int times);
		repeat (times) begin
			next_cycle();
			i_keys = k;
			repeat (4) next_cycle();
			i_keys = '0;
			repeat (4) next_cycle();
		end
	endtask

	// starts and ends at the seconds position
	task automatic set_fields(input hms_t from, input hms_t to);
		int n_sec;
		int n_min;
		int n_hr;
		n_sec = (int'(to.sec) - int'(from.sec) + 60) % 60;
		n_min = (int'(to.min) - int'(from.min) + 60) % 60;
		n_hr  = (int'(to.hr) - int'(from.hr) + 24) % 24;
		press_keys(k_inc, n_sec);
		if (n_min != 0 || n_hr != 0) begin
			press_keys(k_pos, 1);
			press_keys(k_inc, n_min);
			press_keys(k_pos, 1);
			press_keys(k_inc, n_hr);
			press_keys(k_pos, 1);	// back to seconds
		end
	endtask

	// first lit pattern of each digit as seen on the falling edge
	task automatic read_display(output hms_t t, output bit ok);
		seg_t pat [NUM_DIGITS];
		bit   seen [NUM_DIGITS];
		int   d [NUM_DIGITS];
		int   n_seen;
		int   cycles;
		int   idx;
		n_seen = 0;
		cycles = 0;
		ok     = 1'b1;
		t      = '0;
		for (int i = 0; i < NUM_DIGITS; i++)
			seen[i] = 1'b0;
		while (n_seen < NUM_DIGITS && cycles < READ_LIMIT) begin
			@(negedge clk);
			cycles++;
			idx = enb_to_index(o_seg_enb);
			if (idx >= 0 && o_seg != SEG_BLANK && !seen[idx]) begin
				pat[idx]  = o_seg;
				seen[idx] = 1'b1;
				n_seen++;
			end
		end
		if (n_seen < NUM_DIGITS) begin
			errors++;
			ok = 1'b0;
			$display("timeout at %0t ns: not every display digit lit up", $time);
		end else begin
			for (int i = 0; i < NUM_DIGITS; i++) begin
				d[i] = seg_to_digit(pat[i]);
				if (d[i] < 0)
					ok = 1'b0;
			end
			t.sec = unit_t'(d[1] * 10 + d[0]);
			t.min = unit_t'(d[3] * 10 + d[2]);
			t.hr  = unit_t'(d[5] * 10 + d[4]);
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s", $time, what);
		end
	endtask

	task automatic check_time(input hms_t got, input hms_t exp, input string what);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s read %02d:%02d:%02d, expected %02d:%02d:%02d",
				$time, what, got.hr, got.min, got.sec, exp.hr, exp.min, exp.sec);
		end
	endtask

	// mixed reads across a tick of the running clock are skipped
	task automatic wait_for_time(input hms_t exp);
		hms_t got;
		bit   ok;
		bit   found;
		int   tries;
		found = 1'b0;
		tries = 0;
		while (!found && tries < READ_TRIES) begin
			read_display(got, ok);
			tries++;
			if (ok && got == exp)
				found = 1'b1;
		end
		if (!found) begin
			errors++;
			$display("timeout at %0t ns: display never showed %02d:%02d:%02d",
				$time, exp.hr, exp.min, exp.sec);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		$display("%s: finished with %0d error(s)", name, errors - err_before);
	endtask

	// --------------------------------------------------------------------------
	// test sequence
	// --------------------------------------------------------------------------
	initial begin
		hms_t got;
		hms_t t0;
		hms_t target;
		hms_t exp;
		hms_t now;
		hms_t alarm_time;
		bit   ok;
		int   cycles;
		int   err0;
		int   asrt_fails;

		rst_n   = 1'b0;
		i_keys  = '0;
		k_mode  = '0;
		k_pos   = '0;
		k_inc   = '0;
		k_alarm = '0;
		k_mode.mode      = 1'b1;
		k_pos.pos        = 1'b1;
		k_inc.inc        = 1'b1;
		k_alarm.alarm_en = 1'b1;
		repeat (2) next_cycle();
		rst_n = 1'b1;

		// test 1 checks the reset state
		err0 = errors;
		read_display(got, ok);
		check_true(ok, "display decodes after reset");
		check_time(got, '0, "time after reset");
		check_true(!o_alarm, "alarm low after reset");
		check_true($onehot(~o_seg_enb), "one digit enabled after reset");
		report_test("reset state", err0);

		// test 2 sets 23:58:57 field by field
		err0 = errors;
		press_keys(k_mode, 1);
		read_display(t0, ok);
		check_true(ok, "display decodes in set time");
		target = '{hr: 6'd23, min: 6'd58, sec: 6'd57};
		set_fields(t0, target);
		read_display(got, ok);
		check_time(got, target, "time after setting");
		repeat (3 * TB_SEC_DIV) next_cycle();	// three seconds worth
		read_display(got, ok);
		check_time(got, target, "time frozen in set mode");
		report_test("set time", err0);

		// test 3 has manual increments wrap without carry
		err0 = errors;
		press_keys(k_inc, 3);
		press_keys(k_pos, 2);
		press_keys(k_inc, 1);
		press_keys(k_pos, 1);
		exp     = target;
		exp.sec = unit_t'((int'(target.sec) + 3) % 60);
		exp.hr  = unit_t'((int'(target.hr) + 1) % 24);
		read_display(got, ok);
		check_time(got, exp, "time after wrapping increments");
		report_test("wrap without carry", err0);

		// test 4 runs across midnight
		err0 = errors;
		set_fields(exp, from_secs(DAY_SECS - 2));
		read_display(got, ok);
		check_time(got, from_secs(DAY_SECS - 2), "time before running");
		press_keys(k_mode, 2);	// through set alarm to clock
		wait_for_time(from_secs(DAY_SECS - 1));
		wait_for_time(from_secs(0));
		report_test("running with carries", err0);

		// test 5 sets the alarm three seconds ahead
		err0 = errors;
		read_display(now, ok);
		check_true(ok, "display decodes before alarm setup");
		alarm_time = from_secs((to_secs(now) + 3) % DAY_SECS);
		press_keys(k_mode, 2);
		set_fields('0, alarm_time);
		press_keys(k_alarm, 1);
		press_keys(k_mode, 1);
		cycles = 0;
		while (!o_alarm && cycles < ALARM_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!o_alarm) begin
			errors++;
			$display("timeout at %0t ns: alarm output never rose", $time);
		end
		read_display(got, ok);
		check_true(ok && to_secs(got) >= to_secs(alarm_time), "time not before alarm time");
		press_keys(k_alarm, 1);
		check_true(!o_alarm, "alarm low after disable");
		report_test("alarm", err0);

		asrt_fails = clock_top_inst.clock_assert_inst.fail_count;
		$display("checks: %0d, check errors: %0d, assertion failures: %0d",
			checks, errors, asrt_fails);
		if (errors == 0 && asrt_fails == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
hdl/clock_pkg.sv
hdl/tick_gen.sv
hdl/key_cond.sv
hdl/mode_ctrl.sv
hdl/timekeeper.sv
hdl/alarm_unit.sv
hdl/display_mux.sv
hdl/clock_top.sv
sim/clock_assert.sv
sim/tb_clock_top.sv
